//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Address of the first instruction fetched after reset.
`define CPU_RESET_PC 32'h0000_0004

// A JR to this address stops the core.
`define CPU_HALT_ADDR 32'h0000_0000

// Number of general purpose registers.
`define CPU_NUM_REGS 32

`endif

//--- src/cpu_pkg.sv
package cpu_pkg;

    // Primary opcode field, bits 31 to 26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09
    } opcode_e;

    // Function field of SPECIAL instructions, bits 5 to 0.
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_JR    = 6'h08,
        FN_MFHI  = 6'h10,
        FN_MFLO  = 6'h12,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23
    } funct_e;

    // Operation selected by decode for the execute stage.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_MULT,
        ALU_MULTU,
        ALU_MFHI,
        ALU_MFLO,
        ALU_JUMP,
        ALU_NOP
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] op_a;     // Value of rs.
        logic [31:0] op_b;     // Value of rt or the extended immediate.
        logic [4:0]  shamt;
        logic [4:0]  dest;
        logic        wr_en;
    } decoded_t;

    typedef struct packed {
        logic        wr_en;
        logic [4:0]  wr_addr;
        logic [31:0] wr_data;
        logic        jump_taken;
        logic [31:0] jump_target;
    } result_t;

endpackage

//--- src/cpu_fetch.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_fetch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             waitrequest,
    input  logic [31:0]      readdata,
    input  cpu_pkg::result_t jump,
    output logic [31:0]      address,
    output logic             read,
    output logic [31:0]      instruction,
    output logic             execute_en,
    output logic             active
);

    typedef enum logic {
        ST_FETCH,
        ST_EXECUTE
    } state_e;

    state_e      state;
    logic [31:0] pc;
    logic        halted;
    logic        done;

    // A read completes on the edge where waitrequest is low.
    assign done = active && (state == ST_FETCH) && !waitrequest;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_FETCH;
            pc     <= `CPU_RESET_PC;
            active <= 1'b0;
            halted <= 1'b0;
        end else if (!active) begin
            if (!halted) begin
                active <= 1'b1;                      // Start running on the first edge.
            end
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!waitrequest) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    state <= ST_FETCH;
                    if (jump.jump_taken) begin
                        pc <= jump.jump_target;
                        if (jump.jump_target == `CPU_HALT_ADDR) begin
                            active <= 1'b0;          // Stop fetching for good.
                            halted <= 1'b1;
                        end
                    end else begin
                        pc <= pc + 32'd4;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Instruction word latched from the bus.
    always_ff @(posedge clk) begin
        if (done) begin
            instruction <= readdata;
        end
    end

    assign address    = pc;
    assign read       = active && (state == ST_FETCH);   // Held until waitrequest drops.
    assign execute_en = (state == ST_EXECUTE);

endmodule

//--- src/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
    input  logic [31:0]       instruction,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    output logic [4:0]        rs_addr,
    output logic [4:0]        rt_addr,
    output cpu_pkg::decoded_t decoded
);

    cpu_pkg::opcode_e opcode;
    cpu_pkg::funct_e  funct;
    logic [4:0]       rd;
    logic [4:0]       shamt;
    logic [31:0]      imm_ext;

    assign opcode  = cpu_pkg::opcode_e'(instruction[31:26]);
    assign funct   = cpu_pkg::funct_e'(instruction[5:0]);
    assign rs_addr = instruction[25:21];
    assign rt_addr = instruction[20:16];
    assign rd      = instruction[15:11];
    assign shamt   = instruction[10:6];
    assign imm_ext = {{16{instruction[15]}}, instruction[15:0]};   // Sign extended immediate.

    always_comb begin
        decoded.op    = cpu_pkg::ALU_NOP;     // Unknown codes fall through as a NOP.
        decoded.op_a  = rs_data;
        decoded.op_b  = rt_data;
        decoded.shamt = shamt;
        decoded.dest  = rd;
        decoded.wr_en = 1'b0;

        case (opcode)
            cpu_pkg::OP_ADDIU: begin
                decoded.op    = cpu_pkg::ALU_ADD;
                decoded.op_b  = imm_ext;
                decoded.dest  = rt_addr;      // I-type writes rt.
                decoded.wr_en = 1'b1;
            end
            cpu_pkg::OP_SPECIAL: begin
                case (funct)
                    cpu_pkg::FN_ADDU: begin
                        decoded.op    = cpu_pkg::ALU_ADD;
                        decoded.wr_en = 1'b1;
                    end
                    cpu_pkg::FN_SUBU: begin
                        decoded.op    = cpu_pkg::ALU_SUB;
                        decoded.wr_en = 1'b1;
                    end
                    cpu_pkg::FN_SLL: begin
                        decoded.op    = cpu_pkg::ALU_SLL;
                        decoded.wr_en = 1'b1;
                    end
                    cpu_pkg::FN_MFHI: begin
                        decoded.op    = cpu_pkg::ALU_MFHI;
                        decoded.wr_en = 1'b1;
                    end
                    cpu_pkg::FN_MFLO: begin
                        decoded.op    = cpu_pkg::ALU_MFLO;
                        decoded.wr_en = 1'b1;
                    end
                    cpu_pkg::FN_MULT:  decoded.op = cpu_pkg::ALU_MULT;
                    cpu_pkg::FN_MULTU: decoded.op = cpu_pkg::ALU_MULTU;
                    cpu_pkg::FN_JR:    decoded.op = cpu_pkg::ALU_JUMP;
                    default:           decoded.op = cpu_pkg::ALU_NOP;
                endcase
            end
            default: decoded.op = cpu_pkg::ALU_NOP;
        endcase
    end

endmodule

//--- src/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              execute_en,
    input  cpu_pkg::decoded_t decoded,
    output cpu_pkg::result_t  result
);

    logic [31:0]        hi;
    logic [31:0]        lo;
    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;
    logic [31:0]        sum;
    logic [31:0]        diff;
    logic [31:0]        shifted;

    assign sum     = decoded.op_a + decoded.op_b;         // Wraps, no overflow trap.
    assign diff    = decoded.op_a - decoded.op_b;
    assign shifted = decoded.op_b << decoded.shamt;       // SLL shifts rt.

    assign prod_s = $signed(decoded.op_a) * $signed(decoded.op_b);
    assign prod_u = {32'd0, decoded.op_a} * {32'd0, decoded.op_b};

    // HI and LO only change on the execute edge of a multiply.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= 32'd0;
            lo <= 32'd0;
        end else if (execute_en) begin
            if (decoded.op == cpu_pkg::ALU_MULT) begin
                hi <= prod_s[63:32];
                lo <= prod_s[31:0];
            end else if (decoded.op == cpu_pkg::ALU_MULTU) begin
                hi <= prod_u[63:32];
                lo <= prod_u[31:0];
            end
        end
    end

    always_comb begin
        result.wr_en       = decoded.wr_en;
        result.wr_addr     = decoded.dest;
        result.jump_taken  = (decoded.op == cpu_pkg::ALU_JUMP);
        result.jump_target = decoded.op_a;                // JR target comes from rs.

        case (decoded.op)
            cpu_pkg::ALU_ADD:  result.wr_data = sum;
            cpu_pkg::ALU_SUB:  result.wr_data = diff;
            cpu_pkg::ALU_SLL:  result.wr_data = shifted;
            cpu_pkg::ALU_MFHI: result.wr_data = hi;
            cpu_pkg::ALU_MFLO: result.wr_data = lo;
            default:           result.wr_data = 32'd0;
        endcase
    end

endmodule

//--- src/cpu_result.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_result (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             execute_en,
    input  cpu_pkg::result_t result,
    input  logic [4:0]       rs_addr,
    input  logic [4:0]       rt_addr,
    output logic [31:0]      rs_data,
    output logic [31:0]      rt_data,
    output logic [31:0]      register_v0
);

    logic [31:0] regs [`CPU_NUM_REGS];
    logic        wr_fire;

    // Writes to $zero are dropped here.
    assign wr_fire = execute_en && result.wr_en && (result.wr_addr != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_fire) begin
            regs[result.wr_addr] <= result.wr_data;
        end
    end

    // Register zero is never written, so it always reads as zero.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign register_v0 = regs[2];   // Live copy of v0 for the ports.

endmodule

//--- src/top_level_cpu.sv
`timescale 1ns/1ps

module top_level_cpu (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    logic [31:0]       instruction;
    logic              execute_en;
    logic [4:0]        rs_addr;
    logic [4:0]        rt_addr;
    logic [31:0]       rs_data;
    logic [31:0]       rt_data;
    cpu_pkg::decoded_t decoded;
    cpu_pkg::result_t  result;

    cpu_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .jump        (result),
        .address     (address),
        .read        (read),
        .instruction (instruction),
        .execute_en  (execute_en),
        .active      (active)
    );

    cpu_decode u_decode (
        .instruction (instruction),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .decoded     (decoded)
    );

    cpu_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .execute_en (execute_en),
        .decoded    (decoded),
        .result     (result)
    );

    cpu_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .execute_en  (execute_en),
        .result      (result),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

endmodule

//--- testbench/avalon_rom_model.sv
`timescale 1ns/1ps

module avalon_rom_model (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    output logic        waitrequest,
    output logic [31:0] readdata,
    input  logic        load_en,      // Load port, one word and its stall per cycle.
    input  logic [5:0]  load_addr,
    input  logic [31:0] load_data,
    input  logic [3:0]  load_stall
);

    logic [31:0] mem [64];
    logic [3:0]  stall [64];          // Cycles of waitrequest before each word is returned.
    logic [3:0]  wait_cnt;
    logic [5:0]  word_idx;

    assign word_idx    = address[7:2];
    assign waitrequest = read && (wait_cnt < stall[word_idx]);
    assign readdata    = read ? mem[word_idx] : 32'd0;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr]   <= load_data;
            stall[load_addr] <= load_stall;
        end
        // The count restarts once a read completes or the bus goes idle.
        if (read && waitrequest) begin
            wait_cnt <= wait_cnt + 4'd1;
        end else begin
            wait_cnt <= 4'd0;
        end
    end

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        load_en;
    logic [5:0]  load_addr;
    logic [31:0] load_data;
    logic [3:0]  load_stall;
    logic [31:0] rand_state;
    logic [31:0] prog [$];            // Program body, the closing JR $0 is added on load.

    top_level_cpu UUT (.*);
    avalon_rom_model u_rom (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] addiu_word(input int rt, input int rs, input logic [15:0] imm);
        return {6'h09, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] rtype_word(input int rd, rs, rt, sh, fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // After JR $0 the core stays idle and no read reaches the bus.
    task automatic check_halt();
        repeat (20) begin
            @(negedge clk);
            if (active !== 1'b0 || read !== 1'b0) begin
                stop_with_failure($sformatf("MISMATCH active/read: got %h/%h, expected 0/0",
                                            active, read));
            end
        end
    endtask

    // Mode 0 stalls each fetch 0 to 3 cycles, mode 1 never, mode 2 only the third fetch, long.
    task automatic run_check(input string name, input logic [31:0] exp, input int mode);
        logic [31:0] r;
        int          n;
        prog.push_back(32'h0000_0008);
        for (n = 0; n < prog.size(); n++) begin
            r = next_rand();
            @(posedge clk);
            load_en    <= 1'b1;
            load_addr  <= 6'((`CPU_RESET_PC >> 2) + n);
            load_data  <= prog[n];
            load_stall <= (mode == 0) ? {2'b00, r[1:0]} :
                          ((mode == 2 && n == 2) ? 4'd15 : 4'd0);
        end
        void'(prog.pop_back());
        @(posedge clk);
        load_en <= 1'b0;
        rst_n   <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);                // Active rises on the first edge.
        if (active !== 1'b1 || read !== 1'b1) begin
            stop_with_failure("The core did not start fetching on the first edge after reset.");
        end
        check_word("address", address, `CPU_RESET_PC);
        n = 0;
        while (active !== 1'b0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (active !== 1'b0) begin
            stop_with_failure("Timeout, the core did not halt within 2000 cycles.");
        end
        check_word(name, register_v0, exp);
    endtask

    task automatic test_add_sub();
        logic [15:0] a;
        logic [15:0] b;
        a = 16'(next_rand());
        b = 16'(next_rand());
        prog.delete();
        prog.push_back(addiu_word(8, 0, a));
        prog.push_back(addiu_word(9, 0, b));
        prog.push_back(rtype_word(2, 8, 9, 0, 'h21));
        run_check("register_v0 after addu", sext16(a) + sext16(b), 0);
        prog[2] = rtype_word(2, 8, 9, 0, 'h23);
        run_check("register_v0 after subu", sext16(a) - sext16(b), 0);
    endtask

    task automatic test_shift();
        logic [15:0] a;
        int          sh;
        a = 16'(next_rand());
        prog.delete();
        prog.push_back(addiu_word(8, 0, a));
        prog.push_back(32'd0);
        for (sh = 1; sh < 32; sh += 6) begin
            prog[1] = rtype_word(2, 0, 8, sh, 'h00);
            run_check($sformatf("register_v0 after sll by %0d", sh), sext16(a) << sh, 0);
        end
    endtask

    task automatic test_multiply();
        logic [15:0]        a;
        logic [15:0]        b;
        logic [63:0]        pu;
        logic signed [63:0] ps;
        a  = 16'(next_rand()) | 16'h8000;       // Negative operand.
        b  = 16'(next_rand()) | 16'h8000;       // Negative operand.
        pu = {32'd0, sext16(a)} * {32'd0, sext16(b)};
        ps = $signed(sext16(a)) * $signed(sext16(b));
        prog.delete();
        prog.push_back(addiu_word(8, 0, a));
        prog.push_back(addiu_word(9, 0, b));
        prog.push_back(rtype_word(0, 8, 9, 0, 'h19));
        prog.push_back(rtype_word(2, 0, 0, 0, 'h12));
        run_check("register_v0 after multu and mflo", pu[31:0], 0);
        prog[3] = rtype_word(2, 0, 0, 0, 'h10);
        run_check("register_v0 after multu and mfhi", pu[63:32], 0);
        prog[2] = rtype_word(0, 8, 9, 0, 'h18);
        prog[3] = rtype_word(10, 0, 0, 0, 'h10);
        prog.push_back(rtype_word(11, 0, 0, 0, 'h12));
        prog.push_back(rtype_word(2, 10, 11, 0, 'h23));
        run_check("register_v0 after mult, mfhi minus mflo", ps[63:32] - ps[31:0], 0);
    endtask

    task automatic test_zero_and_unknown();
        logic [15:0] a;
        a = 16'(next_rand()) | 16'h0001;        // Never zero.
        prog.delete();
        prog.push_back(addiu_word(2, 0, a));
        prog.push_back(addiu_word(0, 0, a));
        prog.push_back(rtype_word(2, 0, 0, 0, 'h21));
        run_check("register_v0 after addu of $zero", 32'd0, 0);
        prog[1] = {6'h3f, 5'd0, 5'd2, ~a};        // Unknown opcode aimed at v0.
        prog[2] = rtype_word(2, 8, 8, 0, 'h3f);   // Unknown function code.
        run_check("register_v0 after unknown codes", sext16(a), 0);
    endtask

    task automatic test_halt_and_stall();
        prog.delete();
        prog.push_back(addiu_word(8, 0, 16'hfffb));
        prog.push_back(addiu_word(9, 0, 16'h1234));
        prog.push_back(rtype_word(2, 8, 9, 0, 'h23));
        run_check("register_v0 without stalls", sext16(16'hfffb) - sext16(16'h1234), 1);
        check_halt();
        run_check("register_v0 with a long stall", sext16(16'hfffb) - sext16(16'h1234), 2);
        check_halt();
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        load_en    = 1'b0;
        load_addr  = 6'd0;
        load_data  = 32'd0;
        load_stall = 4'd0;
        rand_state = 32'h1e1921ec;
        test_add_sub();
        test_shift();
        test_multiply();
        test_zero_and_unknown();
        test_halt_and_stall();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_result.sv
src/top_level_cpu.sv
testbench/avalon_rom_model.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = cpu_tb
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
